/* include/cpu16_settings.svh */
`ifndef CPU16_SETTINGS_SVH
`define CPU16_SETTINGS_SVH

`define CPU16_XLEN        16   // Data, PC and instruction width
`define CPU16_NREGS       16
`define CPU16_IMEM_DEPTH  64   // Words
`define CPU16_DMEM_DEPTH  32   // Words

`define CPU16_RIDX_W   $clog2(`CPU16_NREGS)
`define CPU16_IADDR_W  $clog2(`CPU16_IMEM_DEPTH)
`define CPU16_DADDR_W  $clog2(`CPU16_DMEM_DEPTH)

`endif

/* source/cpu16_pkg.sv */
package cpu16_pkg;

    // Major opcode in bits 15:12
    typedef enum logic [3:0] {
        OP_ALU  = 4'h0,   // r1 = r1 op r2
        OP_ADDI = 4'h1,   // r1 = r1 + sext(imm8)
        OP_LW   = 4'h2,   // r1 = dmem[r2]
        OP_SW   = 4'h3,   // dmem[r2] = r1
        OP_BEQ  = 4'h4,   // Offset in func field
        OP_JMP  = 4'h5,   // PC relative, imm12
        OP_HALT = 4'hF
    } opcode_t;

    // ALU function in bits 3:0 of an ALU_R word
    typedef enum logic [3:0] {
        F_ADD = 4'h0,
        F_SUB = 4'h1,
        F_AND = 4'h2,
        F_OR  = 4'h3,
        F_XOR = 4'h4,
        F_SLL = 4'h5,
        F_SRL = 4'h6
    } alu_func_t;

    // Operand source picked by the hazard unit
    typedef enum logic [1:0] {
        FWD_RF = 2'd0,   // Register file
        FWD_EX = 2'd1,   // ALU result in execute
        FWD_WB = 2'd2    // Writeback register
    } fwd_sel_t;

    // Register form, also BEQ with the offset in func
    typedef struct packed {
        opcode_t    op;
        logic [3:0] r1;
        logic [3:0] r2;
        logic [3:0] func;
    } instr_r_t;

    typedef struct packed {
        opcode_t    op;
        logic [3:0] r1;
        logic [7:0] imm8;
    } instr_i_t;

    typedef struct packed {
        opcode_t     op;
        logic [11:0] imm12;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

endpackage

/* source/cpu16_regfile.sv */
`include "cpu16_settings.svh"

module cpu16_regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`CPU16_RIDX_W-1:0]   rs1_addr,
    input  logic [`CPU16_RIDX_W-1:0]   rs2_addr,
    input  logic                       we,
    input  logic [`CPU16_RIDX_W-1:0]   waddr,
    input  logic [`CPU16_XLEN-1:0]     wdata,
    output logic [`CPU16_XLEN-1:0]     rs1_data,
    output logic [`CPU16_XLEN-1:0]     rs2_data
);

    logic [`CPU16_XLEN-1:0] regs [0:`CPU16_NREGS-1];

    // All registers are general purpose, r0 included
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU16_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;   // Commit from writeback register
        end
    end

    // Old value on a same-cycle write
    // Hazard unit covers it with FWD_WB
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* source/cpu16_hazard_unit.sv */
`include "cpu16_settings.svh"

module cpu16_hazard_unit import cpu16_pkg::*; (
    input  logic [`CPU16_RIDX_W-1:0]   rs1_addr,
    input  logic [`CPU16_RIDX_W-1:0]   rs2_addr,
    input  logic                       uses_r2,
    input  logic                       ex_valid,
    input  logic [`CPU16_RIDX_W-1:0]   ex_rd,
    input  logic                       ex_writes,
    input  logic                       ex_is_load,
    input  logic                       wb_valid,
    input  logic [`CPU16_RIDX_W-1:0]   wb_addr,
    output fwd_sel_t                   fwd1,
    output fwd_sel_t                   fwd2,
    output logic                       stall
);

    logic ex_fwd_ok;   // Execute holds a usable ALU result
    logic load_hit1;
    logic load_hit2;

    // Loaded data only exists after the writeback register
    assign ex_fwd_ok = ex_valid && ex_writes && !ex_is_load;

    // Operand 1, youngest producer first
    always_comb begin
        if (ex_fwd_ok && (ex_rd == rs1_addr)) begin
            fwd1 = FWD_EX;
        end else if (wb_valid && (wb_addr == rs1_addr)) begin
            fwd1 = FWD_WB;   // Also covers the same-cycle RF write
        end else begin
            fwd1 = FWD_RF;
        end
    end

    // Operand 2, same priority
    always_comb begin
        if (ex_fwd_ok && (ex_rd == rs2_addr)) begin
            fwd2 = FWD_EX;
        end else if (wb_valid && (wb_addr == rs2_addr)) begin
            fwd2 = FWD_WB;
        end else begin
            fwd2 = FWD_RF;
        end
    end

    // Load-use, one bubble then FWD_WB picks the value up
    assign load_hit1 = (ex_rd == rs1_addr);
    assign load_hit2 = uses_r2 && (ex_rd == rs2_addr);
    assign stall     = ex_valid && ex_is_load && (load_hit1 || load_hit2);

endmodule

/* source/cpu16_decode_stage.sv */
`include "cpu16_settings.svh"

module cpu16_decode_stage import cpu16_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       run,
    input  logic                       imem_we,
    input  logic [`CPU16_IADDR_W-1:0]  imem_addr,
    input  logic [`CPU16_XLEN-1:0]     imem_wdata,
    input  logic [`CPU16_XLEN-1:0]     rs1_data,
    input  logic [`CPU16_XLEN-1:0]     rs2_data,
    input  fwd_sel_t                   fwd1,
    input  fwd_sel_t                   fwd2,
    input  logic                       stall,
    input  logic [`CPU16_XLEN-1:0]     ex_result,
    input  logic [`CPU16_XLEN-1:0]     wb_data,
    output logic [`CPU16_RIDX_W-1:0]   rs1_addr,
    output logic [`CPU16_RIDX_W-1:0]   rs2_addr,
    output logic                       uses_r2,
    output logic                       ex_valid,
    output opcode_t                    ex_op,
    output alu_func_t                  ex_func,
    output logic [`CPU16_RIDX_W-1:0]   ex_rd,
    output logic [`CPU16_XLEN-1:0]     ex_a,
    output logic [`CPU16_XLEN-1:0]     ex_b,
    output logic [`CPU16_XLEN-1:0]     ex_store_data,
    output logic                       halting
);

    logic [`CPU16_XLEN-1:0] imem [0:`CPU16_IMEM_DEPTH-1];
    logic [`CPU16_XLEN-1:0] pc;
    logic [`CPU16_XLEN-1:0] pc_next;
    instr_u                 ir;
    opcode_t                op;
    logic [`CPU16_XLEN-1:0] opnd1;
    logic [`CPU16_XLEN-1:0] opnd2;
    logic [`CPU16_XLEN-1:0] imm_sext;
    logic [`CPU16_XLEN-1:0] br_off;
    logic [`CPU16_XLEN-1:0] jmp_off;
    logic                   br_taken;
    logic                   issue;

    // Load port, only while the core is stopped
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign ir = imem[pc[`CPU16_IADDR_W-1:0]];   // Async fetch
    assign op = ir.r.op;

    assign rs1_addr = ir.r.r1;
    assign rs2_addr = ir.r.r2;
    assign uses_r2  = (op == OP_ALU) || (op == OP_LW) || (op == OP_SW) || (op == OP_BEQ);

    // Operand 1 source
    always_comb begin
        case (fwd1)
            FWD_EX:  opnd1 = ex_result;
            FWD_WB:  opnd1 = wb_data;
            default: opnd1 = rs1_data;
        endcase
    end

    // Operand 2 source
    always_comb begin
        case (fwd2)
            FWD_EX:  opnd2 = ex_result;
            FWD_WB:  opnd2 = wb_data;
            default: opnd2 = rs2_data;
        endcase
    end

    // Immediates, all sign extended
    assign imm_sext = {{(`CPU16_XLEN-8){ir.i.imm8[7]}}, ir.i.imm8};
    assign br_off   = {{(`CPU16_XLEN-4){ir.r.func[3]}}, ir.r.func};
    assign jmp_off  = {{(`CPU16_XLEN-12){ir.j.imm12[11]}}, ir.j.imm12};

    assign br_taken = (op == OP_BEQ) && (opnd1 == opnd2);   // Forwarded compare

    // Targets are relative to the branch's own PC
    always_comb begin
        case (op)
            OP_BEQ:  pc_next = br_taken ? pc + br_off : pc + 1'b1;
            OP_JMP:  pc_next = pc + jmp_off;
            OP_HALT: pc_next = pc;   // Park on HALT
            default: pc_next = pc + 1'b1;
        endcase
    end

    assign issue = run && !halting && !stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= '0;
            halting  <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue;   // Bubble when stalled, halted or idle
            if (issue) begin
                pc <= pc_next;
                if (op == OP_HALT) begin
                    halting <= 1'b1;   // Sticky until reset
                end
            end
        end
    end

    // Decode/execute pipeline register payload
    always_ff @(posedge clk) begin
        if (issue) begin
            ex_op         <= op;
            ex_func       <= alu_func_t'(ir.r.func);
            ex_rd         <= ir.r.r1;
            ex_a          <= opnd1;
            ex_b          <= (op == OP_ADDI) ? imm_sext : opnd2;   // LW/SW address in r2
            ex_store_data <= opnd1;
        end
    end

endmodule

/* source/cpu16_execute_stage.sv */
`include "cpu16_settings.svh"

module cpu16_execute_stage import cpu16_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ex_valid,
    input  opcode_t                    ex_op,
    input  alu_func_t                  ex_func,
    input  logic [`CPU16_RIDX_W-1:0]   ex_rd,
    input  logic [`CPU16_XLEN-1:0]     ex_a,
    input  logic [`CPU16_XLEN-1:0]     ex_b,
    input  logic [`CPU16_XLEN-1:0]     ex_store_data,
    output logic [`CPU16_XLEN-1:0]     ex_result,
    output logic                       ex_writes,
    output logic                       ex_is_load,
    output logic                       wb_valid,
    output logic [`CPU16_RIDX_W-1:0]   wb_addr,
    output logic [`CPU16_XLEN-1:0]     wb_data,
    output logic                       halted
);

    localparam int SHW = $clog2(`CPU16_XLEN);   // Shift amount width

    logic [`CPU16_XLEN-1:0]    dmem [0:`CPU16_DMEM_DEPTH-1];
    logic [`CPU16_DADDR_W-1:0] daddr;
    logic [`CPU16_XLEN-1:0]    load_data;
    logic [`CPU16_XLEN-1:0]    alu_out;
    logic [SHW-1:0]            shamt;

    assign shamt = ex_b[SHW-1:0];

    // ALU, everything but ALU_R is an add
    always_comb begin
        if (ex_op == OP_ALU) begin
            case (ex_func)
                F_ADD:   alu_out = ex_a + ex_b;
                F_SUB:   alu_out = ex_a - ex_b;
                F_AND:   alu_out = ex_a & ex_b;
                F_OR:    alu_out = ex_a | ex_b;
                F_XOR:   alu_out = ex_a ^ ex_b;
                F_SLL:   alu_out = ex_a << shamt;
                F_SRL:   alu_out = ex_a >> shamt;   // Logical
                default: alu_out = '0;
            endcase
        end else begin
            alu_out = ex_a + ex_b;
        end
    end

    assign ex_result = alu_out;   // Forward path, not valid for loads

    // Qualified with ex_valid by the users
    assign ex_writes  = (ex_op == OP_ALU) || (ex_op == OP_ADDI) || (ex_op == OP_LW);
    assign ex_is_load = (ex_op == OP_LW);

    // Word addressed data memory
    assign daddr     = ex_b[`CPU16_DADDR_W-1:0];
    assign load_data = dmem[daddr];   // Async read

    always_ff @(posedge clk) begin
        if (ex_valid && (ex_op == OP_SW)) begin
            dmem[daddr] <= ex_store_data;
        end
    end

    // Writeback register control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= ex_valid && ex_writes;   // Non-writing ops retire silently
            if (ex_valid && (ex_op == OP_HALT)) begin
                halted <= 1'b1;
            end
        end
    end

    // Writeback payload
    always_ff @(posedge clk) begin
        if (ex_valid && ex_writes) begin
            wb_addr <= ex_rd;
            wb_data <= ex_is_load ? load_data : alu_out;
        end
    end

endmodule

/* source/cpu16_core.sv */
`include "cpu16_settings.svh"

module cpu16_core import cpu16_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       run,
    input  logic                       imem_we,
    input  logic [`CPU16_IADDR_W-1:0]  imem_addr,
    input  logic [`CPU16_XLEN-1:0]     imem_wdata,
    output logic                       wb_valid,
    output logic [`CPU16_RIDX_W-1:0]   wb_addr,
    output logic [`CPU16_XLEN-1:0]     wb_data,
    output logic                       halted
);

    logic [`CPU16_RIDX_W-1:0] rs1_addr;
    logic [`CPU16_RIDX_W-1:0] rs2_addr;
    logic [`CPU16_XLEN-1:0]   rs1_data;
    logic [`CPU16_XLEN-1:0]   rs2_data;
    logic                     uses_r2;
    fwd_sel_t                 fwd1;
    fwd_sel_t                 fwd2;
    logic                     stall;
    logic                     halting;   // Front end frozen after HALT

    // Decode/execute pipeline register
    logic                     ex_valid;
    opcode_t                  ex_op;
    alu_func_t                ex_func;
    logic [`CPU16_RIDX_W-1:0] ex_rd;
    logic [`CPU16_XLEN-1:0]   ex_a;
    logic [`CPU16_XLEN-1:0]   ex_b;
    logic [`CPU16_XLEN-1:0]   ex_store_data;

    logic [`CPU16_XLEN-1:0]   ex_result;
    logic                     ex_writes;
    logic                     ex_is_load;

    cpu16_decode_stage u_decode (
        .clk           (clk),
        .rst           (rst),
        .run           (run),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .fwd1          (fwd1),
        .fwd2          (fwd2),
        .stall         (stall),
        .ex_result     (ex_result),
        .wb_data       (wb_data),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .uses_r2       (uses_r2),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_func       (ex_func),
        .ex_rd         (ex_rd),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_store_data (ex_store_data),
        .halting       (halting)
    );

    cpu16_hazard_unit u_hazard (
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .uses_r2    (uses_r2),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_writes  (ex_writes),
        .ex_is_load (ex_is_load),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .fwd1       (fwd1),
        .fwd2       (fwd2),
        .stall      (stall)
    );

    cpu16_execute_stage u_execute (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_func       (ex_func),
        .ex_rd         (ex_rd),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_store_data (ex_store_data),
        .ex_result     (ex_result),
        .ex_writes     (ex_writes),
        .ex_is_load    (ex_is_load),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .halted        (halted)
    );

    // Written from the writeback register
    cpu16_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .we       (wb_valid),
        .waddr    (wb_addr),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

/* bench/cpu16_core_chk.sv */
`include "cpu16_settings.svh"

module cpu16_core_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   stall,
    input logic                   wb_valid,
    input logic                   halted,
    input logic [`CPU16_XLEN-1:0] pc
);

    int fail_count = 0;   // Failed assertions so far

    // Nothing retires once HALT has reached writeback
    no_wb_after_halt: assert property (@(posedge clk) disable iff (rst) halted |-> !wb_valid)
        else begin
            $error("wb_valid set while halted");
            fail_count++;
        end

    // Load-use costs exactly one bubble
    single_cycle_stall: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
        else begin
            $error("stall held for two cycles");
            fail_count++;
        end

    pc_held_on_stall: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc))
        else begin
            $error("PC moved across a stalled edge");
            fail_count++;
        end

    halted_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin
            $error("halted fell without reset");   // Only reset clears it
            fail_count++;
        end

endmodule

bind cpu16_core cpu16_core_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .wb_valid (wb_valid),
    .halted   (halted),
    .pc       (u_decode.pc)
);

/* bench/cpu16_core_tb.sv */
`include "cpu16_settings.svh"

module cpu16_core_tb import cpu16_pkg::*;;

    localparam int EXP_BASE  = 'h40;   // Expected writebacks in the vectors image
    localparam int PROG_BASE = 'h02;
    localparam int TIMEOUT   = 2000;   // Cycles allowed until halted

    logic                      clk;
    logic                      rst;
    logic                      run;
    logic                      imem_we;
    logic [`CPU16_IADDR_W-1:0] imem_addr;
    logic [`CPU16_XLEN-1:0]    imem_wdata;
    logic                      wb_valid;
    logic [`CPU16_RIDX_W-1:0]  wb_addr;
    logic [`CPU16_XLEN-1:0]    wb_data;
    logic                      halted;

    logic [19:0] vec [0:127];   // Header, program, expected list
    int          prog_len;
    int          exp_count;
    int          wb_count;
    int          cycles;

    cpu16_core uut (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_reg_addr(input string sig, input logic [`CPU16_RIDX_W-1:0] got,
                                  input logic [`CPU16_RIDX_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, sig, got, exp));
    endtask

    task automatic check_word(input string sig, input logic [`CPU16_XLEN-1:0] got,
                              input logic [`CPU16_XLEN-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, sig, got, exp));
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, sig, got, exp));
    endtask

    // Writeback monitor, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (uut.u_chk.fail_count != 0)
            abort_run("An assertion in the bound checker failed");
        if (!rst && run) begin
            if ($isunknown(wb_valid) || $isunknown(halted))
                abort_run("Writeback valid or halted flag is unknown while running");
            if (halted && wb_valid)
                abort_run("A writeback appeared after the core halted");
            if (wb_valid) begin
                if (wb_count >= exp_count)
                    abort_run("More writebacks than the expected list holds");
                check_reg_addr("wb_addr", wb_addr, vec[EXP_BASE + wb_count][19:16]);
                check_word("wb_data", wb_data, vec[EXP_BASE + wb_count][15:0]);
                wb_count++;
            end
        end
    end

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        wb_count   = 0;
        exp_count  = 0;
        $readmemh("bench/cpu16_vectors.txt", vec);
        if ($isunknown(vec[0]) || $isunknown(vec[1]))
            abort_run("The vectors file could not be read");
        prog_len  = int'(vec[0]);
        exp_count = int'(vec[1]);

        repeat (2) @(posedge clk);
        #10 rst = 1'b0;

        // Idle after reset, nothing retired yet
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("halted", halted, 1'b0);

        // Program load while run is low
        for (int i = 0; i < prog_len; i++) begin
            imem_we    = 1'b1;
            imem_addr  = i[`CPU16_IADDR_W-1:0];
            imem_wdata = vec[PROG_BASE + i][15:0];
            @(posedge clk);
            #10;
        end
        imem_we = 1'b0;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("halted", halted, 1'b0);
        run = 1'b1;

        cycles = 0;
        while (halted !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (halted !== 1'b1)
            abort_run("Timed out waiting for halted after 2000 cycles");

        // Short window so a late writeback would be caught
        repeat (4) @(posedge clk);
        #10;
        if (wb_count != exp_count) begin
            abort_run($sformatf("** Error at %0t: %s = %0d, expected %0d",
                                $time, "writeback count", wb_count, exp_count));
        end else if (uut.u_chk.fail_count != 0) begin
            abort_run("An assertion in the bound checker failed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* bench/cpu16_vectors.txt */
// Columns: 20-bit hex words, several per line
// @00 program length and expected writeback count, @02 program, @40 {reg[19:16], data[15:0]}
@00
0001D 0001A
@02
// 0-3 ADDI r1..r4, r2 gets a negative value
01105 012FD 0130C 0140A
// 4-8 ADD, SUB, OR, AND, XOR back to back
00340 00311 00433 00422 00414
// 9-12 ADDI r5, SLL, SRL, ADDI negative
01503 00455 00416 012FE
// 13-16 SW then LW, then load-use ADD
01604 03460 02760 00710
// 17-21 BEQ taken on forwarded operands, skipped ADDI, BEQ not taken
0180C 04782 01963 04122 01A01
// 22-28 counter setup, loop body, BEQ exit, JMP back, HALT
01B03 01D00 01C02 01BFF 04BD2 05FFD 0F000
@40
// Writebacks in program order
10005 2FFFD 3000C 4000A
30016 30011 4001B 40019 4001C
50003 400E0 40007 2FFFB
60004 70007 7000C
8000C A0001
// Loop runs three times
B0003 D0000 C0002 B0002 C0004 B0001 C0006 B0000

/* cpu16_core.f */
+incdir+include
source/cpu16_pkg.sv
source/cpu16_regfile.sv
source/cpu16_hazard_unit.sv
source/cpu16_decode_stage.sv
source/cpu16_execute_stage.sv
source/cpu16_core.sv
bench/cpu16_core_chk.sv
bench/cpu16_core_tb.sv

/* Bender.yml */
package:
  name: cpu16_core

sources:
  - include_dirs:
      - include
    files:
      - source/cpu16_pkg.sv
      - source/cpu16_regfile.sv
      - source/cpu16_hazard_unit.sv
      - source/cpu16_decode_stage.sv
      - source/cpu16_execute_stage.sv
      - source/cpu16_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/cpu16_core_chk.sv
      - bench/cpu16_core_tb.sv
